/* logic/adcTypesPkg.sv */
// Sample, lane and FIFO word types and the start-up settling constants shared by the ADC path
package adcTypesPkg;

  // Width of one lane in the packed FIFO word
  // Wide enough for the largest legal ADC width of 16 bits
  localparam int laneBits = 16;

  // One two's-complement sample, zero-padded above the ADC width
  typedef logic [laneBits-1:0] laneT;

  // Packed FIFO word
  // Q sits in the upper lane and I in the lower lane
  typedef logic [2*laneBits-1:0] fifoWordT;

  // Settling counter width
  // Must hold settleCycles without wrapping
  localparam int settleBits = 5;

  // Counter type for the start-up settling period
  typedef logic [settleBits-1:0] settleCountT;

  // ADC pipeline delay after reset release, in ADC clock cycles
  // The counter stops here and writing is enabled one cycle later
  localparam settleCountT settleCycles = settleCountT'(16);

endpackage

/* logic/fifoCfgPkg.sv */
// Depth default and synchronizer configuration of the clock-crossing sample FIFO
package fifoCfgPkg;

  // Default FIFO address width
  // 9 address bits give 512 words of storage
  localparam int defaultAddrBits = 9;

  // Flops in each Gray pointer synchronizer
  // Two stages settle a metastable capture before the flag logic sees it
  // More stages add latency to the full and empty flags
  localparam int syncStages = 2;

endpackage

/* logic/adcCapture.sv */
// ADC-domain capture that converts I/Q samples, waits out start-up settling and feeds the FIFO
`timescale 1ns/1ps

module adcCapture #(
  // ADC width, legal values 10, 14 or 16
  parameter int sampleBits = 10
) (
  input  logic                   ADC_CLK_IN,
  input  logic                   DSP_RST_IN,
  input  logic [sampleBits-1:0]  adcDataI,
  input  logic [sampleBits-1:0]  adcDataQ,
  input  logic                   fifoFull,
  output adcTypesPkg::fifoWordT  wrData,
  output logic                   wrEn,
  output logic                   overflow
);

  // One converted sample at the native ADC width
  typedef logic [sampleBits-1:0] sampleT;

  sampleT convI;
  sampleT convQ;
  adcTypesPkg::laneT laneI;
  adcTypesPkg::laneT laneQ;
  adcTypesPkg::settleCountT settleCount;
  logic settled;

  // Offset binary to two's complement
  // Only the MSB flips, the magnitude bits pass unchanged
  function automatic sampleT toTwos(input sampleT raw);
    return {~raw[sampleBits-1], raw[sampleBits-2:0]};
  endfunction

  // Input register for both channels
  // Conversion happens on the way in so the word is ready one cycle later
  always_ff @(posedge ADC_CLK_IN) begin
    convI <= toTwos(adcDataI);
    convQ <= toTwos(adcDataQ);
  end

  // Zero-pad each sample up to a full lane
  assign laneI = adcTypesPkg::laneT'(convI);
  assign laneQ = adcTypesPkg::laneT'(convQ);

  // Q over I in the packed word
  assign wrData = {laneQ, laneI};

  // Settling counter and write qualifier
  // Counter stops at settleCycles, settled rises on the following edge
  always_ff @(posedge ADC_CLK_IN or posedge DSP_RST_IN) begin
    if (DSP_RST_IN) begin
      settleCount <= '0;
      settled     <= 1'b0;
      overflow    <= 1'b0;
    end else begin
      if (settleCount != adcTypesPkg::settleCycles) begin
        settleCount <= settleCount + 1'b1;
      end
      if (settleCount == adcTypesPkg::settleCycles) begin
        settled <= 1'b1;
      end
      // A settled sample that meets a full FIFO is lost
      // Flag stays up until the next reset
      if (settled && fifoFull) begin
        overflow <= 1'b1;
      end
    end
  end

  // Every settled sample is written unless the FIFO is full
  assign wrEn = settled & ~fifoFull;

  // FIFO fills only from settled writes
  // Full before settling means its flags left reset wrong
  fullOnlyWhenSettled: assert property (
    @(posedge ADC_CLK_IN) disable iff (DSP_RST_IN)
    fifoFull |-> settled
  );

  // Overflow is sticky between resets
  overflowSticky: assert property (
    @(posedge ADC_CLK_IN) disable iff (DSP_RST_IN)
    !$fell(overflow)
  );

endmodule

/* logic/cdcSampleFifo.sv */
// Dual-clock sample FIFO with Gray-coded pointers carrying packed I/Q words from ADC to DSP clock
`timescale 1ns/1ps

module cdcSampleFifo #(
  // Depth is 2**addrBits words, at least 2 address bits
  parameter int addrBits = 9
) (
  input  logic                   ADC_CLK_IN,
  input  logic                   DSP_CLK_IN,
  input  logic                   DSP_RST_IN,
  input  adcTypesPkg::fifoWordT  wrData,
  input  logic                   wrEn,
  input  logic                   rdEn,
  output adcTypesPkg::fifoWordT  rdData,
  output logic                   fifoFull,
  output logic                   fifoEmpty
);

  localparam int depth = 1 << addrBits;
  localparam int syncDepth = fifoCfgPkg::syncStages;

  // Pointer with one extra wrap bit above the address
  typedef logic [addrBits:0] ptrT;
  // Memory address
  typedef logic [addrBits-1:0] addrT;

  adcTypesPkg::fifoWordT mem [depth];

  ptrT wrBin;
  ptrT wrBinNext;
  ptrT wrGray;
  ptrT wrGrayNext;
  ptrT rdBin;
  ptrT rdBinNext;
  ptrT rdGray;
  ptrT rdGrayNext;
  ptrT rdGraySync [syncDepth];
  ptrT wrGraySync [syncDepth];
  ptrT rdGrayInWr;
  ptrT wrGrayInRd;
  addrT wrAddr;
  addrT rdAddr;
  logic wrInc;
  logic rdInc;
  logic fullNext;
  logic emptyNext;

  function automatic ptrT bin2Gray(input ptrT bin);
    return bin ^ (bin >> 1);
  endfunction

  // Write side, ADC clock

  // Pointer only advances on an accepted write
  assign wrInc      = wrEn & ~fifoFull;
  assign wrBinNext  = wrBin + ptrT'(wrInc);
  assign wrGrayNext = bin2Gray(wrBinNext);
  assign wrAddr     = wrBin[addrBits-1:0];

  // Read pointer as seen from the write domain
  assign rdGrayInWr = rdGraySync[syncDepth-1];

  // Full when the write pointer is one lap ahead
  // In Gray code that means the top two bits differ and the rest match
  assign fullNext = (wrGrayNext == {~rdGrayInWr[addrBits -: 2],
                                    rdGrayInWr[addrBits-2:0]});

  always_ff @(posedge ADC_CLK_IN or posedge DSP_RST_IN) begin
    if (DSP_RST_IN) begin
      wrBin    <= '0;
      wrGray   <= '0;
      fifoFull <= 1'b0;
      for (int i = 0; i < syncDepth; i++) begin
        rdGraySync[i] <= '0;
      end
    end else begin
      wrBin    <= wrBinNext;
      wrGray   <= wrGrayNext;
      fifoFull <= fullNext;
      // Read Gray pointer crossing into the ADC clock
      rdGraySync[0] <= rdGray;
      for (int i = 1; i < syncDepth; i++) begin
        rdGraySync[i] <= rdGraySync[i-1];
      end
    end
  end

  // Storage, written in the ADC domain only
  always_ff @(posedge ADC_CLK_IN) begin
    if (wrInc) begin
      mem[wrAddr] <= wrData;
    end
  end

  // Read side, DSP clock

  assign rdInc      = rdEn & ~fifoEmpty;
  assign rdBinNext  = rdBin + ptrT'(rdInc);
  assign rdGrayNext = bin2Gray(rdBinNext);
  assign rdAddr     = rdBin[addrBits-1:0];

  // Write pointer as seen from the read domain
  assign wrGrayInRd = wrGraySync[syncDepth-1];

  // Empty when both pointers meet including the wrap bit
  assign emptyNext = (rdGrayNext == wrGrayInRd);

  always_ff @(posedge DSP_CLK_IN or posedge DSP_RST_IN) begin
    if (DSP_RST_IN) begin
      rdBin     <= '0;
      rdGray    <= '0;
      fifoEmpty <= 1'b1;
      for (int i = 0; i < syncDepth; i++) begin
        wrGraySync[i] <= '0;
      end
    end else begin
      rdBin     <= rdBinNext;
      rdGray    <= rdGrayNext;
      fifoEmpty <= emptyNext;
      // Write Gray pointer crossing into the DSP clock
      wrGraySync[0] <= wrGray;
      for (int i = 1; i < syncDepth; i++) begin
        wrGraySync[i] <= wrGraySync[i-1];
      end
    end
  end

  // Read data register, holds the last word read
  always_ff @(posedge DSP_CLK_IN) begin
    if (rdInc) begin
      rdData <= mem[rdAddr];
    end
  end

  // Producer respects the full flag
  fifoNoOverWrite: assert property (
    @(posedge ADC_CLK_IN) disable iff (DSP_RST_IN)
    !(wrEn && fifoFull)
  );

  // Consumer respects the empty flag
  fifoNoUnderRead: assert property (
    @(posedge DSP_CLK_IN) disable iff (DSP_RST_IN)
    !(rdEn && fifoEmpty)
  );

endmodule

/* logic/dspReadPacer.sv */
// DSP-domain reader that drains the sample FIFO and presents I/Q samples with a valid strobe
`timescale 1ns/1ps

module dspReadPacer #(
  // ADC width, legal values 10, 14 or 16
  parameter int sampleBits = 10
) (
  input  logic                   DSP_CLK_IN,
  input  logic                   DSP_RST_IN,
  input  adcTypesPkg::fifoWordT  rdData,
  input  logic                   fifoEmpty,
  input  logic                   dspEnable,
  output logic                   rdEn,
  output logic                   sampleValid,
  output logic [sampleBits-1:0]  sampleI,
  output logic [sampleBits-1:0]  sampleQ
);

  // Bit position of the Q lane in the packed word
  localparam int qBase = adcTypesPkg::laneBits;

  // High while rdData holds a freshly read word
  logic dataReady;

  // Read whenever a word is waiting and the DSP side allows it
  // Back-to-back reads keep one read in flight behind each output
  assign rdEn = ~fifoEmpty & dspEnable;

  // Valid pipeline
  // FIFO data register lands one edge after the read, outputs one edge later
  always_ff @(posedge DSP_CLK_IN or posedge DSP_RST_IN) begin
    if (DSP_RST_IN) begin
      dataReady   <= 1'b0;
      sampleValid <= 1'b0;
    end else begin
      dataReady   <= rdEn;
      sampleValid <= dataReady;
    end
  end

  // Output registers hold the last sample between valid pulses
  // Padding above sampleBits is dropped
  always_ff @(posedge DSP_CLK_IN) begin
    if (dataReady) begin
      sampleI <= rdData[sampleBits-1:0];
      sampleQ <= rdData[qBase +: sampleBits];
    end
  end

  // Every valid pulse traces back to a read two edges earlier
  validFollowsRead: assert property (
    @(posedge DSP_CLK_IN) disable iff (DSP_RST_IN)
    sampleValid |-> $past(rdEn, 2)
  );

endmodule

/* logic/adcFrontEnd.sv */
// Top level of the dual-channel ADC front end, capture through FIFO to DSP-side reader
`timescale 1ns/1ps

module adcFrontEnd #(
  // ADC width, legal values 10, 14 or 16
  parameter int sampleBits = 10,
  // FIFO depth as a power of two
  parameter int addrBits = fifoCfgPkg::defaultAddrBits
) (
  input  logic                   ADC_CLK_IN,
  input  logic                   DSP_CLK_IN,
  input  logic                   DSP_RST_IN,
  input  logic [sampleBits-1:0]  adcDataI,
  input  logic [sampleBits-1:0]  adcDataQ,
  input  logic                   dspEnable,
  output logic                   sampleValid,
  output logic [sampleBits-1:0]  sampleI,
  output logic [sampleBits-1:0]  sampleQ,
  output logic                   overflow
);

  // ADC side of the FIFO
  adcTypesPkg::fifoWordT wrData;
  logic wrEn;
  logic fifoFull;

  // DSP side of the FIFO
  adcTypesPkg::fifoWordT rdData;
  logic rdEn;
  logic fifoEmpty;

  adcCapture #(
    .sampleBits (sampleBits)
  ) adcCapture_inst (
    .ADC_CLK_IN (ADC_CLK_IN),
    .DSP_RST_IN (DSP_RST_IN),
    .adcDataI   (adcDataI),
    .adcDataQ   (adcDataQ),
    .fifoFull   (fifoFull),
    .wrData     (wrData),
    .wrEn       (wrEn),
    .overflow   (overflow)
  );

  // Crossing from ADC clock to DSP clock
  cdcSampleFifo #(
    .addrBits (addrBits)
  ) cdcSampleFifo_inst (
    .ADC_CLK_IN (ADC_CLK_IN),
    .DSP_CLK_IN (DSP_CLK_IN),
    .DSP_RST_IN (DSP_RST_IN),
    .wrData     (wrData),
    .wrEn       (wrEn),
    .rdEn       (rdEn),
    .rdData     (rdData),
    .fifoFull   (fifoFull),
    .fifoEmpty  (fifoEmpty)
  );

  dspReadPacer #(
    .sampleBits (sampleBits)
  ) dspReadPacer_inst (
    .DSP_CLK_IN  (DSP_CLK_IN),
    .DSP_RST_IN  (DSP_RST_IN),
    .rdData      (rdData),
    .fifoEmpty   (fifoEmpty),
    .dspEnable   (dspEnable),
    .rdEn        (rdEn),
    .sampleValid (sampleValid),
    .sampleI     (sampleI),
    .sampleQ     (sampleQ)
  );

endmodule

/* tb/adcFrontEndTb.sv */
// Testbench for the ADC front end, feeds ramp and random samples and checks the DSP-side stream
`timescale 1ns/1ps

module adcFrontEndTb;

  localparam int sampleBits = 10;
  localparam int addrBits = 4;
  // First write lands on the ADC edge after this many edges from reset release
  localparam int settleEdges = 17;
  localparam logic [sampleBits-1:0] signBit = 10'h200;

  logic ADC_CLK_IN;
  logic DSP_CLK_IN;
  logic DSP_RST_IN;
  logic [sampleBits-1:0] adcDataI;
  logic [sampleBits-1:0] adcDataQ;
  logic dspEnable;
  logic sampleValid;
  logic [sampleBits-1:0] sampleI;
  logic [sampleBits-1:0] sampleQ;
  logic overflow;

  // Scoreboard of raw {Q, I} input pairs in write order
  logic [2*sampleBits-1:0] expQueue [$];
  // Raw I of every output, in arrival order
  logic [sampleBits-1:0] rawLog [$];
  logic [2*sampleBits-1:0] expPair;
  logic [2*sampleBits-1:0] firstPair;
  logic [sampleBits-1:0] heldI;
  logic [sampleBits-1:0] heldQ;
  logic [31:0] randState;
  logic firstPushPending;
  logic firstOutPending;
  int adcEdges;
  int dropCount;
  int outCount;
  int errorCount;
  int errorsAtStart;
  int testCount;
  int testFails;
  int checkCount;
  int logBase;
  int dropsBefore;
  string curTest;

  adcFrontEnd #(
    .sampleBits (sampleBits),
    .addrBits   (addrBits)
  ) adcFrontEnd_inst (
    .ADC_CLK_IN  (ADC_CLK_IN),
    .DSP_CLK_IN  (DSP_CLK_IN),
    .DSP_RST_IN  (DSP_RST_IN),
    .adcDataI    (adcDataI),
    .adcDataQ    (adcDataQ),
    .dspEnable   (dspEnable),
    .sampleValid (sampleValid),
    .sampleI     (sampleI),
    .sampleQ     (sampleQ),
    .overflow    (overflow)
  );

  initial begin
    ADC_CLK_IN = 1'b0;
    forever #5 ADC_CLK_IN = ~ADC_CLK_IN;
  end

  // DSP side runs faster than the ADC
  initial begin
    DSP_CLK_IN = 1'b0;
    forever #3 DSP_CLK_IN = ~DSP_CLK_IN;
  end

  function automatic logic [31:0] lcgNext(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  // ADC edges since reset release, saturating far past settling
  always @(posedge ADC_CLK_IN or posedge DSP_RST_IN) begin
    if (DSP_RST_IN) begin
      adcEdges <= 0;
    end else if (adcEdges < 1000) begin
      adcEdges <= adcEdges + 1;
    end
  end

  // ADC-side monitor and stimulus
  // The pair presented last cycle is written on the coming edge unless the FIFO is full
  always @(negedge ADC_CLK_IN) begin
    if (DSP_RST_IN) begin
      expQueue.delete();
      dropCount = 0;
      firstPushPending = 1'b1;
    end else if (adcEdges >= settleEdges) begin
      if (adcFrontEnd_inst.fifoFull) begin
        dropCount++;
      end else begin
        if (firstPushPending) begin
          firstPair = {heldQ, heldI};
          firstPushPending = 1'b0;
        end
        expQueue.push_back({heldQ, heldI});
      end
    end
    // Ramp on I, random on Q
    randState = lcgNext(randState);
    heldI = heldI + 1'b1;
    heldQ = randState[31:22];
    adcDataI = heldI;
    adcDataQ = heldQ;
  end

  // DSP-side monitor, outputs are stable mid-cycle
  always @(negedge DSP_CLK_IN) begin
    if (DSP_RST_IN) begin
      firstOutPending = 1'b1;
    end else if (sampleValid) begin
      if (expQueue.size() == 0) begin
        errorCount++;
        $display("ERROR %s: output sample arrived with no sample expected", curTest);
      end else begin
        expPair = expQueue.pop_front();
        checkCount += 2;
        // Converted value is the raw input with its MSB flipped
        outIMatch: assert (sampleI == (expPair[sampleBits-1:0] ^ signBit)) else begin
          errorCount++;
          $display("FAIL %s sampleI expected %h actual %h", curTest,
                   expPair[sampleBits-1:0] ^ signBit, sampleI);
        end
        outQMatch: assert (sampleQ == (expPair[2*sampleBits-1:sampleBits] ^ signBit)) else begin
          errorCount++;
          $display("FAIL %s sampleQ expected %h actual %h", curTest,
                   expPair[2*sampleBits-1:sampleBits] ^ signBit, sampleQ);
        end
      end
      // First output after reset is the first pair written
      if (firstOutPending) begin
        firstOutPending = 1'b0;
        checkCount++;
        firstMatch: assert ({sampleQ, sampleI} == (firstPair ^ {signBit, signBit})) else begin
          errorCount++;
          $display("FAIL %s first pair expected %h actual %h", curTest,
                   firstPair ^ {signBit, signBit}, {sampleQ, sampleI});
        end
      end
      rawLog.push_back(sampleI ^ signBit);
      outCount++;
    end
  end

  // Nothing leaves before the first write after reset
  noEarlyOutput: assert property (
    @(posedge DSP_CLK_IN) disable iff (DSP_RST_IN)
    (adcEdges <= settleEdges) |-> !sampleValid
  ) else begin
    errorCount++;
    $display("ERROR %s: sampleValid rose before the settling delay ended", curTest);
  end

  // Valid trails the read by two DSP edges, so a low enable there blocks it
  noOutputWhenHeld: assert property (
    @(posedge DSP_CLK_IN) disable iff (DSP_RST_IN)
    !$past(dspEnable, 2) |-> !sampleValid
  ) else begin
    errorCount++;
    $display("ERROR %s: sampleValid rose while the DSP side held reads off", curTest);
  end

  overflowKept: assert property (
    @(posedge ADC_CLK_IN) disable iff (DSP_RST_IN)
    !$fell(overflow)
  ) else begin
    errorCount++;
    $display("ERROR %s: overflow cleared without a reset", curTest);
  end

  // Overflow only after a sample was really dropped
  overflowHasCause: assert property (
    @(posedge ADC_CLK_IN) disable iff (DSP_RST_IN)
    overflow |-> (dropCount > 0)
  ) else begin
    errorCount++;
    $display("ERROR %s: overflow set although no sample was dropped", curTest);
  end

  task automatic expectEqual(input string what, input int expected, input int actual);
    checkCount++;
    valueMatch: assert (expected == actual) else begin
      errorCount++;
      $display("FAIL %s %s expected %0d actual %0d", curTest, what, expected, actual);
    end
  endtask

  // A timeout counts as an error and the run goes on to its closing report
  task automatic reportTimeout(input string what);
    errorCount++;
    $display("ERROR %s: timed out waiting for %s", curTest, what);
  endtask

  // Wait for a number of further output samples, bounded in DSP cycles
  task automatic waitOutputs(input int count, input int limit);
    int target;
    int cycles;
    target = outCount + count;
    cycles = 0;
    while (outCount < target && cycles <= limit) begin
      @(negedge DSP_CLK_IN);
      cycles++;
    end
    if (outCount < target) begin
      reportTimeout("output samples");
    end
  endtask

  task automatic setEnable(input logic level);
    @(negedge DSP_CLK_IN);
    dspEnable = level;
  endtask

  // Reset for 3 ADC cycles, flags checked while it is held
  task automatic applyReset();
    @(negedge ADC_CLK_IN);
    DSP_RST_IN = 1'b1;
    repeat (3) @(negedge ADC_CLK_IN);
    expectEqual("overflow in reset", 0, int'(overflow));
    expectEqual("sampleValid in reset", 0, int'(sampleValid));
    DSP_RST_IN = 1'b0;
  endtask

  task automatic startTest(input string name);
    curTest = name;
    errorsAtStart = errorCount;
  endtask

  task automatic endTest();
    testCount++;
    if (errorCount == errorsAtStart) begin
      $display("test %s: ok", curTest);
    end else begin
      testFails++;
      $display("test %s: %0d errors", curTest, errorCount - errorsAtStart);
    end
  endtask

  initial begin
    DSP_RST_IN = 1'b1;
    dspEnable = 1'b1;
    adcDataI = '0;
    adcDataQ = '0;
    heldI = '0;
    heldQ = '0;
    randState = 32'h2737012b;
    firstPushPending = 1'b1;
    firstOutPending = 1'b1;
    errorCount = 0;
    testCount = 0;
    testFails = 0;
    checkCount = 0;
    outCount = 0;

    startTest("settle");
    applyReset();
    waitOutputs(1, 100);
    endTest();

    startTest("stream");
    waitOutputs(60, 400);
    endTest();

    // Short hold stays below the FIFO depth
    startTest("backpressure");
    dropsBefore = dropCount;
    setEnable(1'b0);
    repeat (10) @(negedge ADC_CLK_IN);
    expectEqual("overflow", 0, int'(overflow));
    setEnable(1'b1);
    waitOutputs(30, 400);
    expectEqual("dropped samples", dropsBefore, dropCount);
    expectEqual("overflow", 0, int'(overflow));
    endTest();

    // Long hold fills all 16 words, the rest is dropped
    startTest("overflow");
    setEnable(1'b0);
    repeat (40) @(negedge ADC_CLK_IN);
    expectEqual("overflow", 1, int'(overflow));
    expectEqual("stored words", 16, expQueue.size());
    logBase = rawLog.size();
    setEnable(1'b1);
    waitOutputs(17, 300);
    checkCount++;
    freshAfterGap: assert (rawLog[logBase+16] != rawLog[logBase+15] + 1'b1) else begin
      errorCount++;
      $display("ERROR %s: no gap between stored and fresh samples", curTest);
    end
    waitOutputs(20, 400);
    expectEqual("overflow", 1, int'(overflow));
    endTest();

    startTest("reset");
    applyReset();
    waitOutputs(1, 100);
    waitOutputs(20, 300);
    expectEqual("overflow", 0, int'(overflow));
    endTest();

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             testCount, testFails, checkCount, errorCount);
    if (errorCount == 0 && testFails == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* vlog.f */
logic/adcTypesPkg.sv
logic/fifoCfgPkg.sv
logic/adcCapture.sv
logic/cdcSampleFifo.sv
logic/dspReadPacer.sv
logic/adcFrontEnd.sv
tb/adcFrontEndTb.sv

/* Makefile */
# Verilator lint and simulation of the ADC front end testbench

TOP := adcFrontEndTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module $(TOP)

# The run passes only when the log holds the pass line
sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) \
		-Mdir obj_dir -o simv
	./obj_dir/simv > sim.log 2>&1; cat sim.log
	grep -q "^Simulation finished: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
